//--- include/rs_mul_consts.svh
`ifndef RS_MUL_CONSTS_SVH
`define RS_MUL_CONSTS_SVH

// reservation station size
`define RS_DEPTH 16

// physical register tag width
`define TAG_W 8

// operand and result word width
`define DATA_W 32

// program counter width
`define PC_W 32

`endif

//--- hdl/rs_mul_pkg.sv
`include "rs_mul_consts.svh"

package rs_mul_pkg;

    typedef logic [`TAG_W-1:0]  tag_t;
    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`PC_W-1:0]   pc_t;

    typedef logic [$clog2(`RS_DEPTH)-1:0] slot_idx_t;

    // which result bus supplied a value
    typedef enum logic [2:0] {
        SRC_NONE = 3'd0,
        SRC_ALU  = 3'd1,
        SRC_MUL  = 3'd2,
        SRC_DIV  = 3'd3,
        SRC_LOAD = 3'd4
    } cdb_src_e;

    typedef enum logic [1:0] {
        SLOT_FREE  = 2'd0,
        SLOT_WAIT  = 2'd1, // at least one operand pending
        SLOT_READY = 2'd2
    } slot_state_e;

endpackage

//--- hdl/tag_snoop.sv
`timescale 1ns/1ns
`include "rs_mul_consts.svh"

module tag_snoop import rs_mul_pkg::*; (
    input  tag_t     tag,
    input  logic     have,
    input  logic     alu_valid,
    input  tag_t     alu_tag,
    input  word_t    alu_data,
    input  logic     mul_valid,
    input  tag_t     mul_tag,
    input  word_t    mul_data,
    input  logic     div_valid,
    input  tag_t     div_tag,
    input  word_t    div_data,
    input  logic     load_valid,
    input  tag_t     load_tag,
    input  word_t    load_data,
    output logic     hit,
    output word_t    hit_data,
    output cdb_src_e hit_src
);

    logic alu_match;
    logic mul_match;
    logic div_match;
    logic load_match;

    assign alu_match  = alu_valid  && (alu_tag  == tag);
    assign mul_match  = mul_valid  && (mul_tag  == tag);
    assign div_match  = div_valid  && (div_tag  == tag);
    assign load_match = load_valid && (load_tag == tag);

    // fixed priority alu > mul > div > load
    always_comb begin
        hit_src  = SRC_NONE;
        hit_data = '0;
        if (!have) begin // only while still pending
            if (alu_match) begin
                hit_src  = SRC_ALU;
                hit_data = alu_data;
            end else if (mul_match) begin
                hit_src  = SRC_MUL;
                hit_data = mul_data;
            end else if (div_match) begin
                hit_src  = SRC_DIV;
                hit_data = div_data;
            end else if (load_match) begin
                hit_src  = SRC_LOAD;
                hit_data = load_data;
            end
        end
    end

    assign hit = (hit_src != SRC_NONE);

endmodule

//--- hdl/rs_entry.sv
`timescale 1ns/1ns
`include "rs_mul_consts.svh"

module rs_entry import rs_mul_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        alloc,
    input  logic        grant,
    input  pc_t         in_pc,
    input  tag_t        in_rd,
    input  tag_t        in_src1_tag,
    input  tag_t        in_src2_tag,
    input  word_t       in_src1_data,
    input  word_t       in_src2_data,
    input  logic        in_src1_valid,
    input  logic        in_src2_valid,
    input  logic        alu_valid,
    input  tag_t        alu_tag,
    input  word_t       alu_data,
    input  logic        mul_valid,
    input  tag_t        mul_tag,
    input  word_t       mul_data,
    input  logic        div_valid,
    input  tag_t        div_tag,
    input  word_t       div_data,
    input  logic        load_valid,
    input  tag_t        load_tag,
    input  word_t       load_data,
    output slot_state_e state,
    output pc_t         pc,
    output tag_t        rd,
    output word_t       src1,
    output word_t       src2
);

    tag_t  src1_tag;
    tag_t  src2_tag;
    logic  src1_valid;
    logic  src2_valid;
    logic  hit1;
    logic  hit2;
    word_t hit1_data;
    word_t hit2_data;
    logic  waiting;
    logic  next1;
    logic  next2;

    assign waiting = (state == SLOT_WAIT);
    assign next1   = src1_valid | (waiting & hit1);
    assign next2   = src2_valid | (waiting & hit2);

    tag_snoop u_snoop1 (
        .tag(src1_tag), .have(src1_valid),
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_data(alu_data),
        .mul_valid(mul_valid), .mul_tag(mul_tag), .mul_data(mul_data),
        .div_valid(div_valid), .div_tag(div_tag), .div_data(div_data),
        .load_valid(load_valid), .load_tag(load_tag), .load_data(load_data),
        .hit(hit1), .hit_data(hit1_data), .hit_src()
    );

    tag_snoop u_snoop2 (
        .tag(src2_tag), .have(src2_valid),
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_data(alu_data),
        .mul_valid(mul_valid), .mul_tag(mul_tag), .mul_data(mul_data),
        .div_valid(div_valid), .div_tag(div_tag), .div_data(div_data),
        .load_valid(load_valid), .load_tag(load_tag), .load_data(load_data),
        .hit(hit2), .hit_data(hit2_data), .hit_src()
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= SLOT_FREE;
            src1_valid <= 1'b0;
            src2_valid <= 1'b0;
        end else if (alloc) begin
            state      <= (in_src1_valid && in_src2_valid) ? SLOT_READY : SLOT_WAIT;
            src1_valid <= in_src1_valid;
            src2_valid <= in_src2_valid;
        end else if (grant) begin
            state <= SLOT_FREE; // slot reusable next cycle
        end else if (waiting) begin
            src1_valid <= next1;
            src2_valid <= next2;
            if (next1 && next2)
                state <= SLOT_READY;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            pc       <= in_pc;
            rd       <= in_rd;
            src1_tag <= in_src1_tag;
            src2_tag <= in_src2_tag;
            src1     <= in_src1_data;
            src2     <= in_src2_data;
        end else if (waiting) begin
            if (hit1)
                src1 <= hit1_data;
            if (hit2)
                src2 <= hit2_data;
        end
    end

endmodule

//--- hdl/slot_select.sv
`timescale 1ns/1ns
`include "rs_mul_consts.svh"

module slot_select import rs_mul_pkg::*; (
    input  slot_state_e states [`RS_DEPTH],
    output slot_idx_t   alloc_idx,
    output logic        alloc_ok,
    output slot_idx_t   grant_idx,
    output logic        grant_ok
);

    // lowest free slot for dispatch
    always_comb begin
        alloc_idx = '0;
        alloc_ok  = 1'b0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin // last hit wins
            if (states[i] == SLOT_FREE) begin
                alloc_idx = slot_idx_t'(i);
                alloc_ok  = 1'b1;
            end
        end
    end

    // lowest ready slot for issue
    // a slot being granted still reads SLOT_READY here, so it is not
    // offered for allocation until its state has gone back to free
    always_comb begin
        grant_idx = '0;
        grant_ok  = 1'b0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (states[i] == SLOT_READY) begin
                grant_idx = slot_idx_t'(i);
                grant_ok  = 1'b1;
            end
        end
    end

endmodule

//--- hdl/rs_mul.sv
`timescale 1ns/1ns
`include "rs_mul_consts.svh"

module rs_mul import rs_mul_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  dispatch,
    input  pc_t   disp_pc,
    input  tag_t  disp_rd,
    input  tag_t  disp_src1_tag,
    input  word_t disp_src1_data,
    input  logic  disp_src1_valid,
    input  tag_t  disp_src2_tag,
    input  word_t disp_src2_data,
    input  logic  disp_src2_valid,
    input  logic  alu_valid,
    input  tag_t  alu_tag,
    input  word_t alu_data,
    input  logic  mul_valid,
    input  tag_t  mul_tag,
    input  word_t mul_data,
    input  logic  div_valid,
    input  tag_t  div_tag,
    input  word_t div_data,
    input  logic  load_valid,
    input  tag_t  load_tag,
    input  word_t load_data,
    output logic  issue_valid,
    output pc_t   issue_pc,
    output tag_t  issue_rd,
    output word_t issue_src1,
    output word_t issue_src2,
    output logic  full
);

    logic        byp1_hit;
    logic        byp2_hit;
    word_t       byp1_data;
    word_t       byp2_data;
    logic        res1_valid;
    logic        res2_valid;
    word_t       res1_data;
    word_t       res2_data;
    slot_state_e slot_state [`RS_DEPTH];
    pc_t         slot_pc    [`RS_DEPTH];
    tag_t        slot_rd    [`RS_DEPTH];
    word_t       slot_src1  [`RS_DEPTH];
    word_t       slot_src2  [`RS_DEPTH];
    slot_idx_t   alloc_idx;
    logic        alloc_ok;
    slot_idx_t   grant_idx;
    logic        grant_ok;

    // same-cycle bypass of dispatch operands
    tag_snoop u_byp1 (
        .tag(disp_src1_tag), .have(disp_src1_valid),
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_data(alu_data),
        .mul_valid(mul_valid), .mul_tag(mul_tag), .mul_data(mul_data),
        .div_valid(div_valid), .div_tag(div_tag), .div_data(div_data),
        .load_valid(load_valid), .load_tag(load_tag), .load_data(load_data),
        .hit(byp1_hit), .hit_data(byp1_data), .hit_src()
    );

    tag_snoop u_byp2 (
        .tag(disp_src2_tag), .have(disp_src2_valid),
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_data(alu_data),
        .mul_valid(mul_valid), .mul_tag(mul_tag), .mul_data(mul_data),
        .div_valid(div_valid), .div_tag(div_tag), .div_data(div_data),
        .load_valid(load_valid), .load_tag(load_tag), .load_data(load_data),
        .hit(byp2_hit), .hit_data(byp2_data), .hit_src()
    );

    assign res1_valid = disp_src1_valid | byp1_hit;
    assign res2_valid = disp_src2_valid | byp2_hit;
    assign res1_data  = byp1_hit ? byp1_data : disp_src1_data;
    assign res2_data  = byp2_hit ? byp2_data : disp_src2_data;

    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_slot
        rs_entry u_entry (
            .clk(clk), .reset(reset),
            .alloc(dispatch && alloc_ok && (alloc_idx == slot_idx_t'(i))), // dropped when full
            .grant(grant_ok && (grant_idx == slot_idx_t'(i))),
            .in_pc(disp_pc), .in_rd(disp_rd),
            .in_src1_tag(disp_src1_tag), .in_src2_tag(disp_src2_tag),
            .in_src1_data(res1_data), .in_src2_data(res2_data),
            .in_src1_valid(res1_valid), .in_src2_valid(res2_valid),
            .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_data(alu_data),
            .mul_valid(mul_valid), .mul_tag(mul_tag), .mul_data(mul_data),
            .div_valid(div_valid), .div_tag(div_tag), .div_data(div_data),
            .load_valid(load_valid), .load_tag(load_tag), .load_data(load_data),
            .state(slot_state[i]), .pc(slot_pc[i]), .rd(slot_rd[i]),
            .src1(slot_src1[i]), .src2(slot_src2[i])
        );
    end

    slot_select u_select (
        .states(slot_state),
        .alloc_idx(alloc_idx), .alloc_ok(alloc_ok),
        .grant_idx(grant_idx), .grant_ok(grant_ok)
    );

    assign full = ~alloc_ok;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            issue_valid <= 1'b0;
        else
            issue_valid <= grant_ok; // one cycle per issued slot
    end

    always_ff @(posedge clk) begin
        if (grant_ok) begin
            issue_pc   <= slot_pc[grant_idx];
            issue_rd   <= slot_rd[grant_idx];
            issue_src1 <= slot_src1[grant_idx];
            issue_src2 <= slot_src2[grant_idx];
        end
    end

endmodule

//--- dv/rs_mul_tb.sv
`timescale 1ns/1ns
`include "rs_mul_consts.svh"

module rs_mul_tb import rs_mul_pkg::*; ();

    localparam int MAX_CYCLES = 2000; // tests need roughly 160 cycles

    logic  clk = 1'b0;
    logic  reset;
    logic  dispatch;
    pc_t   disp_pc;
    tag_t  disp_rd;
    tag_t  disp_src1_tag;
    word_t disp_src1_data;
    logic  disp_src1_valid;
    tag_t  disp_src2_tag;
    word_t disp_src2_data;
    logic  disp_src2_valid;
    logic  alu_valid;
    tag_t  alu_tag;
    word_t alu_data;
    logic  mul_valid;
    tag_t  mul_tag;
    word_t mul_data;
    logic  div_valid;
    tag_t  div_tag;
    word_t div_data;
    logic  load_valid;
    tag_t  load_tag;
    word_t load_data;
    logic  issue_valid;
    pc_t   issue_pc;
    tag_t  issue_rd;
    word_t issue_src1;
    word_t issue_src2;
    logic  full;

    logic [31:0] lfsr_state;
    string       test_name;
    int          cycles = 0;

    rs_mul dut (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    // taps 32 22 2 1 with one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            v = {v[30:0], lfsr_state[31]};
            lfsr_state = {lfsr_state[30:0], fb};
        end
        return v;
    endfunction

    task automatic check(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("** Error: %s %s expected %h actual %h", test_name, what, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic tick();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic idle_inputs();
        dispatch   = 1'b0;
        alu_valid  = 1'b0;
        mul_valid  = 1'b0;
        div_valid  = 1'b0;
        load_valid = 1'b0;
    endtask

    task automatic clear_inputs();
        idle_inputs();
        disp_pc         = '0;
        disp_rd         = '0;
        disp_src1_tag   = '0;
        disp_src1_data  = '0;
        disp_src1_valid = 1'b0;
        disp_src2_tag   = '0;
        disp_src2_data  = '0;
        disp_src2_valid = 1'b0;
        alu_tag         = '0;
        alu_data        = '0;
        mul_tag         = '0;
        mul_data        = '0;
        div_tag         = '0;
        div_data        = '0;
        load_tag        = '0;
        load_data       = '0;
    endtask

    task automatic drive_dispatch(input pc_t pc, input tag_t rd,
                                  input tag_t t1, input word_t d1, input logic v1,
                                  input tag_t t2, input word_t d2, input logic v2);
        dispatch        = 1'b1;
        disp_pc         = pc;
        disp_rd         = rd;
        disp_src1_tag   = t1;
        disp_src1_data  = d1;
        disp_src1_valid = v1;
        disp_src2_tag   = t2;
        disp_src2_data  = d2;
        disp_src2_valid = v2;
    endtask

    task automatic drive_bus(input cdb_src_e bus, input tag_t tg, input word_t d);
        case (bus)
            SRC_ALU: begin
                alu_valid = 1'b1;
                alu_tag   = tg;
                alu_data  = d;
            end
            SRC_MUL: begin
                mul_valid = 1'b1;
                mul_tag   = tg;
                mul_data  = d;
            end
            SRC_DIV: begin
                div_valid = 1'b1;
                div_tag   = tg;
                div_data  = d;
            end
            SRC_LOAD: begin
                load_valid = 1'b1;
                load_tag   = tg;
                load_data  = d;
            end
            default: ;
        endcase
    endtask

    task automatic expect_idle();
        check("issue_valid", word_t'(1'b0), word_t'(issue_valid));
    endtask

    task automatic expect_issue(input pc_t pc, input tag_t rd, input word_t s1, input word_t s2);
        check("issue_valid", word_t'(1'b1), word_t'(issue_valid));
        check("issue_pc", word_t'(pc), word_t'(issue_pc));
        check("issue_rd", word_t'(rd), word_t'(issue_rd));
        check("issue_src1", s1, issue_src1);
        check("issue_src2", s2, issue_src2);
    endtask

    task automatic dispatch_and_issue_ready();
        pc_t   pc;
        tag_t  rd;
        tag_t  t1;
        tag_t  t2;
        word_t s1;
        word_t s2;
        pc = pc_t'(take_bits(`PC_W));
        rd = tag_t'(take_bits(`TAG_W));
        t1 = tag_t'(take_bits(`TAG_W));
        t2 = tag_t'(take_bits(`TAG_W));
        s1 = word_t'(take_bits(`DATA_W));
        s2 = word_t'(take_bits(`DATA_W));
        drive_dispatch(pc, rd, t1, s1, 1'b1, t2, s2, 1'b1);
        tick();
        idle_inputs();
        expect_idle(); // slot ready, issue register not yet loaded
        tick();
        expect_issue(pc, rd, s1, s2);
        tick();
        expect_idle();
    endtask

    task automatic test_ready_dispatch();
        test_name = "test_ready_dispatch";
        for (int i = 0; i < 3; i++)
            dispatch_and_issue_ready();
    endtask

    task automatic test_wakeup_buses();
        cdb_src_e bus;
        pc_t      pc;
        tag_t     rd;
        tag_t     tg;
        word_t    ready_data;
        word_t    junk;
        word_t    bus_data;
        word_t    exp1;
        word_t    exp2;
        for (int b = 1; b <= 4; b++) begin
            for (int op = 1; op <= 2; op++) begin
                bus        = cdb_src_e'(b);
                test_name  = $sformatf("test_wakeup_buses %s op%0d", bus.name(), op);
                pc         = pc_t'(take_bits(`PC_W));
                rd         = tag_t'(take_bits(`TAG_W));
                tg         = tag_t'(take_bits(`TAG_W));
                ready_data = word_t'(take_bits(`DATA_W));
                junk       = word_t'(take_bits(`DATA_W));
                bus_data   = word_t'(take_bits(`DATA_W));
                alu_tag    = tg; // matching tags with valid low
                mul_tag    = tg;
                div_tag    = tg;
                load_tag   = tg;
                if (op == 1) begin
                    drive_dispatch(pc, rd, tg, junk, 1'b0, ~tg, ready_data, 1'b1);
                    exp1 = bus_data;
                    exp2 = ready_data;
                end else begin
                    drive_dispatch(pc, rd, ~tg, ready_data, 1'b1, tg, junk, 1'b0);
                    exp1 = ready_data;
                    exp2 = bus_data;
                end
                tick();
                idle_inputs();
                expect_idle();
                tick();
                expect_idle();
                drive_bus(bus, tg ^ tag_t'(8'h5a), ~bus_data); // wrong tag
                tick();
                idle_inputs();
                expect_idle();
                tick();
                expect_idle();
                drive_bus(bus, tg, bus_data);
                tick();
                idle_inputs();
                expect_idle();
                tick();
                expect_issue(pc, rd, exp1, exp2);
                tick();
                expect_idle();
            end
        end
    endtask

    task automatic test_dispatch_bypass();
        cdb_src_e bus;
        pc_t      pc;
        tag_t     rd;
        tag_t     tg;
        word_t    ready_data;
        word_t    junk;
        word_t    bus_data;
        word_t    load_word;
        for (int b = 1; b <= 5; b++) begin
            pc         = pc_t'(take_bits(`PC_W));
            rd         = tag_t'(take_bits(`TAG_W));
            tg         = tag_t'(take_bits(`TAG_W));
            ready_data = word_t'(take_bits(`DATA_W));
            junk       = word_t'(take_bits(`DATA_W));
            bus_data   = word_t'(take_bits(`DATA_W));
            load_word  = ~bus_data;
            if (b <= 4) begin
                bus       = cdb_src_e'(b);
                test_name = $sformatf("test_dispatch_bypass %s", bus.name());
                drive_dispatch(pc, rd, tg, junk, 1'b0, ~tg, ready_data, 1'b1);
                drive_bus(bus, tg, bus_data);
            end else begin
                test_name = "test_dispatch_bypass alu over load";
                ready_data = bus_data; // both operands wait on the same tag
                drive_dispatch(pc, rd, tg, junk, 1'b0, tg, junk, 1'b0);
                drive_bus(SRC_LOAD, tg, load_word);
                drive_bus(SRC_ALU, tg, bus_data);
            end
            tick();
            idle_inputs();
            expect_idle();
            tick();
            expect_issue(pc, rd, bus_data, ready_data);
            tick();
            expect_idle();
        end
    endtask

    task automatic test_issue_order();
        pc_t   exp_pc [4];
        tag_t  exp_rd [4];
        word_t exp_s1 [4];
        tag_t  tg;
        word_t bus_data;
        word_t junk;
        test_name = "test_issue_order";
        tg        = tag_t'(take_bits(`TAG_W));
        bus_data  = word_t'(take_bits(`DATA_W));
        check("full", word_t'(1'b0), word_t'(full));
        for (int i = 0; i < 4; i++) begin
            exp_pc[i] = pc_t'(take_bits(`PC_W));
            exp_rd[i] = tag_t'(take_bits(`TAG_W));
            exp_s1[i] = word_t'(take_bits(`DATA_W));
            junk      = word_t'(take_bits(`DATA_W));
            drive_dispatch(exp_pc[i], exp_rd[i], ~tg, exp_s1[i], 1'b1, tg, junk, 1'b0);
            tick();
            idle_inputs();
            expect_idle();
        end
        drive_bus(SRC_MUL, tg, bus_data);
        tick();
        idle_inputs();
        expect_idle();
        for (int i = 0; i < 4; i++) begin
            tick();
            expect_issue(exp_pc[i], exp_rd[i], exp_s1[i], bus_data); // dispatch order
        end
        tick();
        expect_idle();
    endtask

    task automatic test_full_drain();
        pc_t   exp_pc [`RS_DEPTH];
        tag_t  exp_rd [`RS_DEPTH];
        word_t exp_s2 [`RS_DEPTH];
        tag_t  tg;
        word_t bus_data;
        word_t junk;
        test_name = "test_full_drain";
        tg        = tag_t'(take_bits(`TAG_W));
        bus_data  = word_t'(take_bits(`DATA_W));
        check("full before dispatch", word_t'(1'b0), word_t'(full));
        for (int i = 0; i < `RS_DEPTH; i++) begin
            exp_pc[i] = pc_t'(take_bits(`PC_W));
            exp_rd[i] = tag_t'(take_bits(`TAG_W));
            exp_s2[i] = word_t'(take_bits(`DATA_W));
            junk      = word_t'(take_bits(`DATA_W));
            drive_dispatch(exp_pc[i], exp_rd[i], tg, junk, 1'b0, ~tg, exp_s2[i], 1'b1);
            tick();
            idle_inputs();
            expect_idle();
            check("full", word_t'(i == `RS_DEPTH - 1), word_t'(full));
        end
        drive_bus(SRC_DIV, tg, bus_data);
        tick();
        idle_inputs();
        expect_idle();
        check("full while all ready", word_t'(1'b1), word_t'(full));
        for (int i = 0; i < `RS_DEPTH; i++) begin
            tick();
            expect_issue(exp_pc[i], exp_rd[i], bus_data, exp_s2[i]);
            check("full while draining", word_t'(1'b0), word_t'(full));
        end
        tick();
        expect_idle();
        test_name = "test_full_drain redispatch";
        dispatch_and_issue_ready();
    endtask

    initial begin
        lfsr_state = 32'h129d6095;
        test_name  = "reset";
        clear_inputs();
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        expect_idle();
        check("full", word_t'(1'b0), word_t'(full));
        test_ready_dispatch();
        test_wakeup_buses();
        test_dispatch_bypass();
        test_issue_order();
        test_full_drain();
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- rs_mul.f
+incdir+include
hdl/rs_mul_pkg.sv
hdl/tag_snoop.sv
hdl/rs_entry.sv
hdl/slot_select.sv
hdl/rs_mul.sv
dv/rs_mul_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the rs_mul testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module rs_mul_tb -f rs_mul.f -o rs_mul_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/rs_mul_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
